// File: src/apb_spi_macros.svh
/* build-time constants of the APB to SPI bridge
   included by the register block and the SPI engine */
`ifndef APB_SPI_MACROS_SVH
`define APB_SPI_MACROS_SVH

// start of the 16-byte register window
`define APB_SPI_BASE_ADDR 32'h0000_0100

// entries in each FIFO, power of two
`define APB_SPI_FIFO_DEPTH 16

// pclk cycles per scl half period
`define APB_SPI_SCL_HALF 4

// 1 for MSB first, 0 for LSB first
`define APB_SPI_MSB_FIRST 1

`endif

// File: src/apb_spi_pkg.sv
/* types shared by the APB to SPI bridge blocks */
`default_nettype none

package apb_spi_pkg;

    // transmit FIFO entry and engine command
    typedef struct packed {
        logic       last;  // release cs after this byte
        logic [7:0] data;
    } tx_entry_t;

    // byte captured from miso
    typedef struct packed {
        logic [7:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic tx_full;
        logic tx_empty;
        logic rx_full;
        logic rx_empty;
    } fifo_status_t;

    // byte offsets inside the window
    typedef enum logic [3:0] {
        REG_TX      = 4'h0,
        REG_TX_LAST = 4'h4,
        REG_STATUS  = 4'h8
    } reg_offset_e;

    // rx data shares the tx offset, read side only
    localparam reg_offset_e REG_RX = REG_TX;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
/* single-clock FIFO for any payload type
   head entry is always on rdata, pop consumes it */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  wire logic     pclk,
    input  wire logic     reset,
    input  wire logic     push,
    input  wire payload_t wdata,
    input  wire logic     pop,
    output payload_t      rdata,
    output logic          full,
    output logic          empty
);

    localparam int aw = $clog2(depth);

    payload_t    mem [depth];
    logic [aw:0] wr_ptr;  // extra msb is the wrap bit
    logic [aw:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign do_push = push && !full;  // push on full is ignored
    assign do_pop  = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign rdata = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge pclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (do_push) begin
            mem[wr_ptr[aw-1:0]] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/apb_fifo_regs.sv
/* APB slave with zero wait states in front of the tx and rx FIFOs
   decodes the register window, builds status and answers errors */
`timescale 1ns/1ps
`default_nettype none
`include "apb_spi_macros.svh"

module apb_fifo_regs
    import apb_spi_pkg::*;
(
    input  wire logic        pclk,
    input  wire logic        reset,

    // apb
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  pwdata,
    output logic             pready,
    output logic [7:0]       prdata,
    output logic             pslverr,

    // transfer side
    input  wire logic        tx_pop,
    output tx_entry_t        tx_head,
    input  wire logic        rx_push,
    input  wire rx_byte_t    rx_data,
    output fifo_status_t     status,
    input  wire logic        busy,
    input  wire logic        overflow,
    output logic             ovf_clear
);

    localparam logic [31:0] base_addr = `APB_SPI_BASE_ADDR;

    logic       access;
    logic       in_window;
    logic [3:0] offset;
    logic       tx_push;
    tx_entry_t  tx_wdata;
    logic       rx_pop;
    rx_byte_t   rx_head;
    logic       status_rd;
    logic       tx_full;
    logic       tx_empty;
    logic       rx_full;
    logic       rx_empty;

    assign access    = psel && penable;
    assign in_window = (paddr[31:4] == base_addr[31:4]);
    assign offset    = paddr[3:0];
    assign pready    = access;  // every access ends in its access phase

    always_comb begin
        tx_push   = 1'b0;
        rx_pop    = 1'b0;
        status_rd = 1'b0;
        pslverr   = 1'b0;
        if (access) begin
            if (!in_window) begin
                pslverr = 1'b1;
            end else if (pwrite) begin
                if (offset == REG_TX || offset == REG_TX_LAST) begin
                    if (tx_full) begin
                        pslverr = 1'b1;  // entry not taken
                    end else begin
                        tx_push = 1'b1;
                    end
                end else begin
                    pslverr = 1'b1;  // unmapped offset treated as a miss
                end
            end else begin
                if (offset == REG_RX) begin
                    if (rx_empty) begin
                        pslverr = 1'b1;
                    end else begin
                        rx_pop = 1'b1;
                    end
                end else if (offset == REG_STATUS) begin
                    status_rd = 1'b1;
                end else begin
                    pslverr = 1'b1;
                end
            end
        end
    end

    assign tx_wdata.data = pwdata;
    assign tx_wdata.last = (offset == REG_TX_LAST);

    always_comb begin
        prdata = '0;
        if (rx_pop) begin
            prdata = rx_head.data;
        end else if (status_rd) begin
            prdata = {2'b00, overflow, busy, rx_full, rx_empty, tx_full, tx_empty};
        end
    end

    assign ovf_clear = status_rd;  // read returns the flag, then clears it

    assign status = '{tx_full: tx_full, tx_empty: tx_empty, rx_full: rx_full, rx_empty: rx_empty};

    sync_fifo #(
        .payload_t (tx_entry_t),
        .depth     (`APB_SPI_FIFO_DEPTH)
    ) u_tx_fifo (
        .pclk  (pclk),
        .reset (reset),
        .push  (tx_push),
        .wdata (tx_wdata),
        .pop   (tx_pop),
        .rdata (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    sync_fifo #(
        .payload_t (rx_byte_t),
        .depth     (`APB_SPI_FIFO_DEPTH)
    ) u_rx_fifo (
        .pclk  (pclk),
        .reset (reset),
        .push  (rx_push),
        .wdata (rx_data),
        .pop   (rx_pop),
        .rdata (rx_head),
        .full  (rx_full),
        .empty (rx_empty)
    );

endmodule

`default_nettype wire

// File: src/spi_engine.sv
/* SPI master shifter in mode 3, one byte per start strobe
   keeps cs low across a frame and raises it after a last entry */
`timescale 1ns/1ps
`default_nettype none
`include "apb_spi_macros.svh"

module spi_engine
    import apb_spi_pkg::*;
(
    input  wire logic      pclk,
    input  wire logic      reset,
    input  wire logic      start,
    input  wire tx_entry_t cmd,
    output logic           done,
    output rx_byte_t       rx_data,
    output logic           busy,
    output logic           scl,
    output logic           mosi,
    input  wire logic      miso,
    output logic           cs
);

    localparam int half      = `APB_SPI_SCL_HALF;
    localparam int hw        = $clog2(half + 1);
    localparam bit msb_first = `APB_SPI_MSB_FIRST;

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_release
    } state_e;

    state_e          state;
    logic [hw-1:0]   half_cnt;
    logic            half_tick;
    logic [3:0]      edge_cnt;  // 16 scl edges per byte
    logic            last_q;
    logic [7:0]      shreg;
    logic            tx_bit;
    logic [7:0]      shift_in;

    assign half_tick = (half_cnt == hw'(half - 1));

    assign tx_bit   = msb_first ? shreg[7] : shreg[0];
    assign shift_in = msb_first ? {shreg[6:0], miso} : {miso, shreg[7:1]};

    assign rx_data.data = shreg;  // stable while done is high
    assign busy         = (state != st_idle) || done;

    always_ff @(posedge pclk) begin
        if (reset) begin
            state    <= st_idle;
            cs       <= 1'b1;
            scl      <= 1'b1;
            mosi     <= 1'b1;
            done     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
            last_q   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_shift;
                        cs       <= 1'b0;
                        half_cnt <= '0;
                        edge_cnt <= '0;
                        last_q   <= cmd.last;
                    end
                end
                st_shift: begin
                    if (half_tick) begin
                        half_cnt <= '0;
                        scl      <= ~scl;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (scl) begin
                            mosi <= tx_bit;  // falling edge drives data
                        end else if (edge_cnt == 4'd15) begin
                            done  <= 1'b1;
                            state <= last_q ? st_release : st_idle;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                st_release: begin
                    if (half_tick) begin
                        cs    <= 1'b1;
                        mosi  <= 1'b1;
                        state <= st_idle;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // load on start, sample miso on each rising scl edge
    always_ff @(posedge pclk) begin
        if (state == st_idle && start) begin
            shreg <= cmd.data;
        end else if (state == st_shift && half_tick && !scl) begin
            shreg <= shift_in;
        end
    end

endmodule

`default_nettype wire

// File: src/spi_transfer_ctrl.sv
/* hands tx entries to the SPI engine and engine results to the rx FIFO
   keeps the sticky overflow flag for bytes dropped on a full rx FIFO */
`timescale 1ns/1ps
`default_nettype none

module spi_transfer_ctrl
    import apb_spi_pkg::*;
(
    input  wire logic         pclk,
    input  wire logic         reset,
    input  wire fifo_status_t status,
    input  wire tx_entry_t    tx_head,
    output logic              tx_pop,
    output logic              start,
    output tx_entry_t         cmd,
    input  wire logic         busy,
    input  wire logic         done,
    input  wire rx_byte_t     eng_data,
    output logic              rx_push,
    output rx_byte_t          rx_data,
    output logic              overflow,
    input  wire logic         ovf_clear
);

    logic issue;

    assign issue  = !busy && !status.tx_empty;  // engine idle and work waiting
    assign tx_pop = issue;
    assign start  = issue;
    assign cmd    = tx_head;

    always_ff @(posedge pclk) begin
        if (reset) begin
            rx_push  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            rx_push <= done && !status.rx_full;
            if (done && status.rx_full) begin
                overflow <= 1'b1;  // a new drop wins over the clear
            end else if (ovf_clear) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (done) begin
            rx_data <= eng_data;
        end
    end

endmodule

`default_nettype wire

// File: src/apb_spi_bridge.sv
/* APB to SPI master bridge top
   register block and SPI engine joined by the transfer controller */
`timescale 1ns/1ps
`default_nettype none

module apb_spi_bridge
    import apb_spi_pkg::*;
(
    input  wire logic        pclk,
    input  wire logic        reset,

    // apb
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  pwdata,
    output logic             pready,
    output logic [7:0]       prdata,
    output logic             pslverr,

    // spi pins
    input  wire logic        miso,
    output logic             mosi,
    output logic             scl,
    output logic             cs
);

    logic         tx_pop;
    tx_entry_t    tx_head;
    logic         rx_push;
    rx_byte_t     rx_data;
    fifo_status_t status;
    logic         busy;
    logic         overflow;
    logic         ovf_clear;
    logic         start;
    tx_entry_t    cmd;
    logic         done;
    rx_byte_t     eng_data;

    apb_fifo_regs u_regs (
        .pclk      (pclk),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .tx_pop    (tx_pop),
        .tx_head   (tx_head),
        .rx_push   (rx_push),
        .rx_data   (rx_data),
        .status    (status),
        .busy      (busy),
        .overflow  (overflow),
        .ovf_clear (ovf_clear)
    );

    spi_engine u_engine (
        .pclk    (pclk),
        .reset   (reset),
        .start   (start),
        .cmd     (cmd),
        .done    (done),
        .rx_data (eng_data),
        .busy    (busy),
        .scl     (scl),
        .mosi    (mosi),
        .miso    (miso),
        .cs      (cs)
    );

    spi_transfer_ctrl u_ctrl (
        .pclk      (pclk),
        .reset     (reset),
        .status    (status),
        .tx_head   (tx_head),
        .tx_pop    (tx_pop),
        .start     (start),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .eng_data  (eng_data),
        .rx_push   (rx_push),
        .rx_data   (rx_data),
        .overflow  (overflow),
        .ovf_clear (ovf_clear)
    );

endmodule

`default_nettype wire

// File: testbench/spi_slave_model.sv
/* behavioral SPI mode-3 slave for the bridge testbench
   records mosi bytes, answers A5 then the inverse of the byte received before */
`timescale 1ns/1ps
`default_nettype none
`include "apb_spi_macros.svh"

module spi_slave_model (
    input  wire logic scl,
    input  wire logic cs,
    input  wire logic mosi,
    output logic      miso,
    output int        frame_cnt,
    output int        byte_cnt
);

    localparam bit msb_first = `APB_SPI_MSB_FIRST;

    logic [7:0] got [1024];  // every byte seen on mosi, in order
    logic [7:0] resp;
    logic [7:0] shift_in;
    int         bit_idx;

    initial begin
        miso      = 1'b1;
        frame_cnt = 0;
        byte_cnt  = 0;
        resp      = 8'hA5;
        shift_in  = 8'h00;
        bit_idx   = 0;
    end

    // new frame restarts the reply rule
    always @(negedge cs) begin
        frame_cnt = frame_cnt + 1;
        resp      = 8'hA5;
        bit_idx   = 0;
    end

    always @(negedge scl) begin
        if (!cs) begin
            miso = msb_first ? resp[7 - bit_idx] : resp[bit_idx];
        end
    end

    always @(posedge scl) begin
        if (!cs) begin
            shift_in = msb_first ? {shift_in[6:0], mosi} : {mosi, shift_in[7:1]};
            bit_idx  = bit_idx + 1;
            if (bit_idx == 8) begin
                if (byte_cnt < 1024) begin
                    got[byte_cnt] = shift_in;
                end
                byte_cnt = byte_cnt + 1;
                resp     = ~shift_in;  // reply for the next byte
                bit_idx  = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_apb_spi_bridge.sv
/* testbench for the APB to SPI bridge with random frames from a fixed seed
   checks mosi bytes, rx data, error responses and rx overflow against a model */
`timescale 1ns/1ps
`default_nettype none
`include "apb_spi_macros.svh"

module tb_apb_spi_bridge
    import apb_spi_pkg::*;
();

    localparam logic [31:0] base       = `APB_SPI_BASE_ADDR;
    localparam int          depth      = `APB_SPI_FIFO_DEPTH;
    localparam int          poll_limit = 4000;

    logic        pclk;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  pwdata;
    logic        pready;
    logic [7:0]  prdata;
    logic        pslverr;
    logic        miso;
    logic        mosi;
    logic        scl;
    logic        cs;
    int          frame_cnt;
    int          byte_cnt;

    // reference model state
    logic [7:0]  exp_mosi [$];
    logic [7:0]  exp_rx [$];
    logic [7:0]  prev_tx;
    logic        frame_open;
    int          exp_frames;
    int          mosi_checked;
    int          value_errors;
    int          other_errors;

    apb_spi_bridge u_dut (
        .pclk    (pclk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .miso    (miso),
        .mosi    (mosi),
        .scl     (scl),
        .cs      (cs)
    );

    spi_slave_model u_slave (
        .scl       (scl),
        .cs        (cs),
        .mosi      (mosi),
        .miso      (miso),
        .frame_cnt (frame_cnt),
        .byte_cnt  (byte_cnt)
    );

    initial begin
        pclk = 1'b0;
        forever #2 pclk = ~pclk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("%0t %s", $time, what);
    endtask

    // setup and access phase, then one idle cycle
    task automatic apb_access(input logic [31:0] addr, input logic write,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output logic err);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        @(negedge pclk);
        penable = 1'b1;
        #1;  // mid access phase
        check_value("pready", 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // slave rule gives A5 first in a frame and then the inverse of the previous byte
    task automatic model_accept(input logic [7:0] data, input logic last);
        exp_mosi.push_back(data);
        exp_rx.push_back(frame_open ? ~prev_tx : 8'hA5);
        prev_tx    = data;
        frame_open = !last;
        if (last) begin
            exp_frames++;
        end
    endtask

    task automatic apb_write_tx(input logic [7:0] data, input logic last, input logic exp_err);
        logic [7:0] unused;
        logic       err;
        apb_access(base + 32'(last ? REG_TX_LAST : REG_TX), 1'b1, data, unused, err);
        check_value("pslverr on tx write", exp_err, err);
        if (!exp_err) begin
            model_accept(data, last);
        end
    endtask

    task automatic read_status(output logic [7:0] st);
        logic err;
        apb_access(base + 32'(REG_STATUS), 1'b0, 8'h00, st, err);
        check_value("pslverr on status read", 1'b0, err);
    endtask

    task automatic read_rx(input logic [7:0] expected);
        logic [7:0] data;
        logic       err;
        apb_access(base + 32'(REG_RX), 1'b0, 8'h00, data, err);
        check_value("pslverr on rx read", 1'b0, err);
        check_value("prdata rx byte", expected, data);
    endtask

    task automatic wait_tx_space();
        logic [7:0] st;
        int         polls;
        polls = 0;
        read_status(st);
        while (st[1] && polls < poll_limit) begin
            read_status(st);
            polls++;
        end
        if (st[1]) begin
            report_failure("timeout waiting for room in the tx FIFO");
        end
    endtask

    // bytes seen by the slave against the written ones, cs high afterwards
    task automatic check_mosi();
        while (mosi_checked < byte_cnt) begin
            if (exp_mosi.size() == 0) begin
                report_failure("slave received a byte that was never written");
                mosi_checked = byte_cnt;
            end else begin
                check_value("mosi byte", exp_mosi.pop_front(), u_slave.got[mosi_checked]);
                mosi_checked++;
            end
        end
        check_value("bytes missing on mosi", 0, exp_mosi.size());
        check_value("cs frame count", exp_frames, frame_cnt);
        check_value("cs between frames", 1'b1, cs);
    endtask

    // read rx bytes as they arrive until the model expects no more
    task automatic drain_frames();
        logic [7:0] st;
        logic       idle;
        int         polls;
        idle  = 1'b0;
        polls = 0;
        while (!idle && polls < poll_limit) begin
            read_status(st);
            if (!st[2] && exp_rx.size() == 0) begin
                report_failure("rx FIFO holds a byte that no written byte predicts");
                idle = 1'b1;
            end else if (!st[2]) begin
                read_rx(exp_rx.pop_front());
            end else begin
                idle = (exp_rx.size() == 0) && st[0] && !st[4];
            end
            polls++;
        end
        if (!idle) begin
            report_failure("timeout waiting for the frames to finish");
        end
        check_mosi();
    endtask

    task automatic random_frame();
        int len;
        len = 1 + ($urandom % 6);
        for (int i = 0; i < len; i++) begin
            apb_write_tx(8'($urandom), i == len - 1, 1'b0);
        end
        drain_frames();
    endtask

    task automatic burst_overfill();
        logic [7:0] st;
        int         polls;
        int         rejected;
        rejected = 0;
        apb_write_tx(8'($urandom), 1'b1, 1'b0);
        polls = 0;
        read_status(st);
        while (!st[1] && polls < 4 * depth) begin
            apb_write_tx(8'($urandom), 1'b0, 1'b0);
            read_status(st);
            polls++;
        end
        if (!st[1]) begin
            report_failure("tx FIFO never became full during the burst");
        end
        // after a pop the next one is a whole byte time away
        polls = 0;
        while (st[1] && polls < poll_limit) begin
            read_status(st);
            polls++;
        end
        if (st[1]) begin
            report_failure("timeout waiting for the engine to take a tx entry");
        end
        for (int i = 0; i < 4; i++) begin
            read_status(st);
            if (st[1]) begin
                rejected++;
            end
            apb_write_tx(8'($urandom), i == 0, st[1]);
        end
        check_value("rejected burst writes", 3, rejected);
        drain_frames();
    endtask

    task automatic overflow_test();
        logic [7:0] st;
        logic [7:0] data;
        logic       err;
        logic       ovf_seen;
        int         polls;
        for (int i = 0; i < depth + 3; i++) begin
            wait_tx_space();
            apb_write_tx(8'($urandom), i == depth + 2, 1'b0);
        end
        while (exp_rx.size() > depth) begin
            data = exp_rx.pop_back();  // these bytes get dropped
        end
        ovf_seen = 1'b0;
        polls    = 0;
        st       = 8'h00;
        while (!(st[0] && !st[4]) && polls < poll_limit) begin
            read_status(st);
            ovf_seen = ovf_seen | (st[3] & st[5]);
            polls++;
        end
        if (!(st[0] && !st[4])) begin
            report_failure("timeout waiting for the overflow frame to finish");
        end
        check_value("status rx_full with overflow", 1'b1, ovf_seen);
        read_status(st);
        check_value("status rx_full", 1'b1, st[3]);
        check_value("status overflow after read", 1'b0, st[5]);
        for (int i = 0; i < depth; i++) begin
            read_rx(exp_rx.pop_front());
        end
        check_mosi();
        apb_access(base + 32'(REG_RX), 1'b0, 8'h00, data, err);
        check_value("pslverr on empty rx read", 1'b1, err);
    endtask

    initial begin
        logic [7:0] st;
        logic [7:0] data;
        logic       err;
        void'($urandom(32'h7b11));
        reset        = 1'b1;
        paddr        = 32'h0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = 8'h00;
        prev_tx      = 8'h00;
        frame_open   = 1'b0;
        exp_frames   = 0;
        mosi_checked = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (4) @(posedge pclk);
        @(negedge pclk);
        reset = 1'b0;

        check_value("cs after reset", 1'b1, cs);
        check_value("scl after reset", 1'b1, scl);
        check_value("mosi after reset", 1'b1, mosi);
        check_value("pslverr after reset", 1'b0, pslverr);
        check_value("pready after reset", 1'b0, pready);
        read_status(st);
        check_value("status after reset", 8'h05, st);

        apb_access(base + 32'(REG_RX), 1'b0, 8'h00, data, err);
        check_value("pslverr on empty rx read", 1'b1, err);
        apb_access(base + 32'h10, 1'b0, 8'h00, data, err);
        check_value("pslverr on read outside window", 1'b1, err);
        apb_access(32'h0000_0000, 1'b1, 8'h3c, data, err);
        check_value("pslverr on write outside window", 1'b1, err);
        read_status(st);
        check_value("status after rejected accesses", 8'h05, st);

        repeat (12) random_frame();
        burst_overfill();
        overflow_test();

        $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/apb_spi_pkg.sv
src/sync_fifo.sv
src/apb_fifo_regs.sv
src/spi_engine.sv
src/spi_transfer_ctrl.sv
src/apb_spi_bridge.sv
testbench/spi_slave_model.sv
testbench/tb_apb_spi_bridge.sv

// File: Bender.yml
package:
  name: apb_spi_bridge

sources:
  - include_dirs:
      - src
    files:
      - src/apb_spi_pkg.sv
      - src/sync_fifo.sv
      - src/apb_fifo_regs.sv
      - src/spi_engine.sv
      - src/spi_transfer_ctrl.sv
      - src/apb_spi_bridge.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/spi_slave_model.sv
      - testbench/tb_apb_spi_bridge.sv
